// ==== design/mbCore_config.svh ====
`ifndef MB_CORE_CONFIG_SVH
`define MB_CORE_CONFIG_SVH

`define MB_RESET_PC   32'h0000_0000  // First fetch after reset
`define MB_NUM_REGS   32             // r0..r31
`define MB_OP_IMM_BIT 3              // Set in every Type B opcode

// Type A arithmetic and logic ops, OR in the Type B bit for the immediate form
`define MB_OP_ADDK    6'b000100
`define MB_OP_RSUBK   6'b000101
`define MB_OP_AND     6'b100001
`define MB_OP_OR      6'b100000
`define MB_OP_XOR     6'b100010

`define MB_OP_LWI     6'b111010      // Word load, rA + imm
`define MB_OP_SWI     6'b111110      // Word store of rD to rA + imm
`define MB_OP_BRI     6'b101110      // Unconditional, PC relative
`define MB_OP_BEQI    6'b101111      // Taken when rA is zero

`endif

// ==== design/mbCore_pkg.sv ====
`default_nettype none

package mbCore_pkg;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [4:0]  rb;
    logic [10:0] func;    // Zero for the ops kept here
  } mbInstrA_s;

  typedef struct packed {
    logic [5:0]  opcode;
    logic [4:0]  rd;
    logic [4:0]  ra;
    logic [15:0] imm;     // Sign extended in decode
  } mbInstrB_s;

  // Same word, field layout picked by the opcode's Type B bit
  typedef union packed {
    mbInstrA_s a;
    mbInstrB_s b;
  } mbInstr_u;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_RSUB,             // B minus A
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_PASSB
  } mbAluOp_e;

  typedef struct packed {
    logic        valid;
    mbAluOp_e    aluOp;
    logic [31:0] opA;
    logic [31:0] opB;     // Register B or sign-extended immediate
    logic [31:0] storeData;
    logic [4:0]  rd;
    logic        regWrite;
    logic        load;
    logic        store;
    logic        branch;
    logic        condBranch;  // BEQI, needs opA == 0
    logic [31:0] pc;
  } mbDecOut_s;

  typedef struct packed {
    logic        valid;   // Set only when a register is written
    logic [4:0]  rd;
    logic        load;    // Result comes from the data port
    logic [31:0] result;
  } mbWb_s;

endpackage

`default_nettype wire

// ==== design/mbFetch.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mbCore_config.svh"

module mbFetch (
  input  wire                  gclk,
  input  wire                  grst,
  input  wire                  advance_i,     // Global pipeline enable
  input  wire                  stall_i,       // Load-use hold from decode
  input  wire                  redirect_i,    // Taken branch in execute
  input  wire  [31:0]          redirectPc_i,
  output logic [31:0]          imemAddr_o,
  output logic                 imemEn_o,
  input  wire  [31:0]          imemData_i,
  output mbCore_pkg::mbInstr_u instr_o,
  output logic [31:0]          instrPc_o,
  output logic                 instrValid_o
);
  import mbCore_pkg::*;

  logic [31:0] pcQ;          // Address on the port this cycle
  logic        enQ;          // Low for one cycle after reset
  logic [31:0] instrPcQ;     // PC of the word now in decode
  logic        instrValidQ;
  mbInstr_u    holdQ;        // Word parked across a stall
  logic        holdValidQ;

  always_ff @(posedge gclk)
  begin
    if (!grst)
    begin
      pcQ         <= `MB_RESET_PC;
      enQ         <= 1'b0;
      instrValidQ <= 1'b0;
      holdValidQ  <= 1'b0;
    end
    else if (advance_i)
    begin
      enQ <= 1'b1;
      if (redirect_i)
      begin
        pcQ         <= redirectPc_i;
        instrValidQ <= 1'b0;            // Word in flight is off path
        holdValidQ  <= 1'b0;
      end
      else if (stall_i)
        holdValidQ <= 1'b1;             // PC held, replay parked word
      else if (enQ)
      begin
        pcQ         <= pcQ + 32'd4;
        instrValidQ <= 1'b1;
        holdValidQ  <= 1'b0;
      end
    end
  end

  always_ff @(posedge gclk)
  begin
    if (advance_i && !stall_i)
      instrPcQ <= pcQ;                  // Follows the request into decode
    if (advance_i && stall_i)
      holdQ <= instr_o;
  end

  assign imemAddr_o   = pcQ;
  assign imemEn_o     = enQ;
  assign instr_o      = holdValidQ ? holdQ : imemData_i;
  assign instrPc_o    = instrPcQ;
  assign instrValid_o = instrValidQ;

endmodule

`default_nettype wire

// ==== design/mbDecode.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mbCore_config.svh"

module mbDecode (
  input  wire                   gclk,
  input  wire                   grst,
  input  wire                   advance_i,
  input  wire                   flush_i,       // Taken branch, squash current
  input  mbCore_pkg::mbInstr_u  instr_i,
  input  wire  [31:0]           instrPc_i,
  input  wire                   instrValid_i,
  output logic [4:0]            raAddr_o,
  output logic [4:0]            rbAddr_o,      // rb, or rd for a store
  input  wire  [31:0]           raData_i,
  input  wire  [31:0]           rbData_i,
  input  mbCore_pkg::mbDecOut_s exFwd_i,
  input  wire  [31:0]           exResult_i,
  input  mbCore_pkg::mbWb_s     wbFwd_i,
  input  wire  [31:0]           wbData_i,
  output logic                  stall_o,
  output mbCore_pkg::mbDecOut_s dec_o
);
  import mbCore_pkg::*;

  logic [5:0]  opcode;
  logic [5:0]  opBase;        // Opcode with the Type B bit cleared
  logic        isImm;
  logic        isAlu;
  logic        isLoad;
  logic        isStore;
  logic        isBri;
  logic        isBeqi;
  logic        useA;
  logic        useB;
  logic [4:0]  rdAddr;
  logic [31:0] simm;
  logic [31:0] fwdA;
  logic [31:0] fwdB;
  mbAluOp_e    aluOp;
  mbDecOut_s   decNext;
  mbDecOut_s   decQ;

  // Execute result first, then writeback, then register file
  function automatic logic [31:0] pickOperand(input logic [4:0]  addr,
                                              input logic [31:0] rfData,
                                              input mbDecOut_s   ex,
                                              input logic [31:0] exData,
                                              input mbWb_s       wb,
                                              input logic [31:0] wbData);
    logic [31:0] val;
    val = rfData;
    if (wb.valid && wb.rd == addr && addr != 5'd0)
      val = wbData;
    if (ex.valid && ex.regWrite && !ex.load && ex.rd == addr && addr != 5'd0)
      val = exData;
    return val;
  endfunction

  assign opcode = instr_i.a.opcode;
  assign isImm  = opcode[`MB_OP_IMM_BIT];
  assign opBase = opcode & ~(6'd1 << `MB_OP_IMM_BIT);

  always_comb
  begin
    isLoad  = (opcode == `MB_OP_LWI);
    isStore = (opcode == `MB_OP_SWI);
    isBri   = (opcode == `MB_OP_BRI);
    isBeqi  = (opcode == `MB_OP_BEQI);
    isAlu   = 1'b1;
    case (opBase)
      `MB_OP_ADDK:  aluOp = ALU_ADD;
      `MB_OP_RSUBK: aluOp = ALU_RSUB;
      `MB_OP_AND:   aluOp = ALU_AND;
      `MB_OP_OR:    aluOp = ALU_OR;
      `MB_OP_XOR:   aluOp = ALU_XOR;
      default:
      begin
        isAlu = 1'b0;
        if (isLoad || isStore)
          aluOp = ALU_ADD;              // Effective address
        else
          aluOp = ALU_PASSB;
      end
    endcase
  end

  // rd and ra sit at the same bits in both layouts
  assign rdAddr   = instr_i.a.rd;
  assign raAddr_o = instr_i.a.ra;
  assign rbAddr_o = isStore ? rdAddr : instr_i.a.rb;
  assign simm     = {{16{instr_i.b.imm[15]}}, instr_i.b.imm};
  assign useA     = isAlu | isLoad | isStore | isBeqi;
  assign useB     = (isAlu & ~isImm) | isStore;

  assign fwdA = pickOperand(raAddr_o, raData_i, exFwd_i, exResult_i, wbFwd_i, wbData_i);
  assign fwdB = pickOperand(rbAddr_o, rbData_i, exFwd_i, exResult_i, wbFwd_i, wbData_i);

  // Load in execute feeding this instruction, data not back yet
  assign stall_o = instrValid_i & exFwd_i.valid & exFwd_i.load & (exFwd_i.rd != 5'd0)
                 & ((useA & (raAddr_o == exFwd_i.rd)) | (useB & (rbAddr_o == exFwd_i.rd)));

  always_comb
  begin
    decNext.valid      = instrValid_i & ~flush_i & ~stall_o;  // Bubble otherwise
    decNext.aluOp      = aluOp;
    decNext.opA        = fwdA;
    decNext.opB        = isImm ? simm : fwdB;
    decNext.storeData  = fwdB;
    decNext.rd         = rdAddr;
    decNext.regWrite   = isAlu | isLoad;
    decNext.load       = isLoad;
    decNext.store      = isStore;
    decNext.branch     = isBri | isBeqi;
    decNext.condBranch = isBeqi;
    decNext.pc         = instrPc_i;
  end

  always_ff @(posedge gclk)
  begin
    if (!grst)
      decQ.valid <= 1'b0;
    else if (advance_i)
      decQ <= decNext;
  end

  assign dec_o = decQ;

endmodule

`default_nettype wire

// ==== design/mbRegFile.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mbCore_config.svh"

module mbRegFile (
  input  wire         gclk,
  input  wire         grst,
  input  wire  [4:0]  raAddr_i,
  input  wire  [4:0]  rbAddr_i,
  output logic [31:0] raData_o,
  output logic [31:0] rbData_o,
  input  wire         we_i,       // Already qualified by advance
  input  wire  [4:0]  waddr_i,
  input  wire  [31:0] wdata_i
);

  logic [31:0] regs [`MB_NUM_REGS];
  logic        wrEn;
  logic        bypassA;
  logic        bypassB;

  assign wrEn = we_i & (waddr_i != 5'd0);   // r0 never written

  always_ff @(posedge gclk)
  begin
    if (grst && wrEn)
      regs[waddr_i] <= wdata_i;
  end

  // Same-cycle write shows through to the reader
  assign bypassA = wrEn & (waddr_i == raAddr_i);
  assign bypassB = wrEn & (waddr_i == rbAddr_i);

  always_comb
  begin
    if (raAddr_i == 5'd0)
      raData_o = 32'd0;                     // r0 reads zero
    else if (bypassA)
      raData_o = wdata_i;
    else
      raData_o = regs[raAddr_i];
  end

  always_comb
  begin
    if (rbAddr_i == 5'd0)
      rbData_o = 32'd0;
    else if (bypassB)
      rbData_o = wdata_i;
    else
      rbData_o = regs[rbAddr_i];
  end

endmodule

`default_nettype wire

// ==== design/mbExecute.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbExecute (
  input  wire                   gclk,
  input  wire                   grst,
  input  wire                   advance_i,
  input  mbCore_pkg::mbDecOut_s dec_i,
  output logic [31:0]           dmemAddr_o,
  output logic [31:0]           dmemData_o,
  output logic                  dmemWe_o,
  output logic                  dmemEn_o,
  input  wire  [31:0]           dmemData_i,    // Load data, valid in writeback
  output logic                  redirect_o,
  output logic [31:0]           redirectPc_o,
  output logic [31:0]           exResult_o,    // Live ALU result for forwarding
  output mbCore_pkg::mbWb_s     wb_o,
  output logic [31:0]           wbData_o,
  output logic                  wbWe_o
);
  import mbCore_pkg::*;

  logic [31:0] aluResult;
  logic        opAZero;
  mbWb_s       wbQ;

  always_comb
  begin
    case (dec_i.aluOp)
      ALU_ADD:   aluResult = dec_i.opA + dec_i.opB;
      ALU_RSUB:  aluResult = dec_i.opB - dec_i.opA;   // rsubk order
      ALU_AND:   aluResult = dec_i.opA & dec_i.opB;
      ALU_OR:    aluResult = dec_i.opA | dec_i.opB;
      ALU_XOR:   aluResult = dec_i.opA ^ dec_i.opB;
      ALU_PASSB: aluResult = dec_i.opB;
      default:   aluResult = dec_i.opB;
    endcase
  end

  assign exResult_o = aluResult;

  // Branches, target is PC plus immediate
  assign opAZero      = (dec_i.opA == 32'd0);
  assign redirect_o   = dec_i.valid & dec_i.branch & (~dec_i.condBranch | opAZero);
  assign redirectPc_o = dec_i.pc + dec_i.opB;

  // Request goes out while the access sits here
  assign dmemAddr_o = aluResult;
  assign dmemData_o = dec_i.storeData;
  assign dmemEn_o   = dec_i.valid & (dec_i.load | dec_i.store);
  assign dmemWe_o   = dec_i.valid & dec_i.store;

  always_ff @(posedge gclk)
  begin
    if (!grst)
      wbQ.valid <= 1'b0;
    else if (advance_i)
    begin
      wbQ.valid  <= dec_i.valid & dec_i.regWrite;
      wbQ.rd     <= dec_i.rd;
      wbQ.load   <= dec_i.load;
      wbQ.result <= aluResult;
    end
  end

  assign wb_o     = wbQ;
  assign wbData_o = wbQ.load ? dmemData_i : wbQ.result;   // Memory data for loads
  assign wbWe_o   = wbQ.valid & advance_i;                // Write lands on advance only

endmodule

`default_nettype wire

// ==== design/mbCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbCore (
  input  wire         gclk,
  input  wire         grst,
  output logic [31:0] imemAddr_o,
  output logic        imemEn_o,
  input  wire  [31:0] imemData_i,
  input  wire         imemBusyN_i,   // Low freezes everything
  output logic [31:0] dmemAddr_o,
  output logic [31:0] dmemData_o,
  output logic        dmemWe_o,
  output logic        dmemEn_o,
  input  wire  [31:0] dmemData_i,
  input  wire         dmemBusyN_i
);
  import mbCore_pkg::*;

  logic        advance;        // Both ports ready
  logic        stall;
  logic        redirect;
  logic [31:0] redirectPc;
  mbInstr_u    instr;
  logic [31:0] instrPc;
  logic        instrValid;
  logic [4:0]  raAddr;
  logic [4:0]  rbAddr;
  logic [31:0] raData;
  logic [31:0] rbData;
  mbDecOut_s   decBundle;      // Decode to execute, also ex forwarding
  logic [31:0] exResult;
  mbWb_s       wbBundle;
  logic [31:0] wbData;
  logic        wbWe;

  assign advance = imemBusyN_i & dmemBusyN_i;

  mbFetch mbFetch_i (
    .gclk         (gclk),
    .grst         (grst),
    .advance_i    (advance),
    .stall_i      (stall),
    .redirect_i   (redirect),
    .redirectPc_i (redirectPc),
    .imemAddr_o   (imemAddr_o),
    .imemEn_o     (imemEn_o),
    .imemData_i   (imemData_i),
    .instr_o      (instr),
    .instrPc_o    (instrPc),
    .instrValid_o (instrValid)
  );

  mbDecode mbDecode_i (
    .gclk         (gclk),
    .grst         (grst),
    .advance_i    (advance),
    .flush_i      (redirect),
    .instr_i      (instr),
    .instrPc_i    (instrPc),
    .instrValid_i (instrValid),
    .raAddr_o     (raAddr),
    .rbAddr_o     (rbAddr),
    .raData_i     (raData),
    .rbData_i     (rbData),
    .exFwd_i      (decBundle),
    .exResult_i   (exResult),
    .wbFwd_i      (wbBundle),
    .wbData_i     (wbData),
    .stall_o      (stall),
    .dec_o        (decBundle)
  );

  mbRegFile mbRegFile_i (
    .gclk     (gclk),
    .grst     (grst),
    .raAddr_i (raAddr),
    .rbAddr_i (rbAddr),
    .raData_o (raData),
    .rbData_o (rbData),
    .we_i     (wbWe),
    .waddr_i  (wbBundle.rd),
    .wdata_i  (wbData)
  );

  mbExecute mbExecute_i (
    .gclk         (gclk),
    .grst         (grst),
    .advance_i    (advance),
    .dec_i        (decBundle),
    .dmemAddr_o   (dmemAddr_o),
    .dmemData_o   (dmemData_o),
    .dmemWe_o     (dmemWe_o),
    .dmemEn_o     (dmemEn_o),
    .dmemData_i   (dmemData_i),
    .redirect_o   (redirect),
    .redirectPc_o (redirectPc),
    .exResult_o   (exResult),
    .wb_o         (wbBundle),
    .wbData_o     (wbData),
    .wbWe_o       (wbWe)
  );

endmodule

`default_nettype wire

// ==== tb/mbCore_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module mbCore_checker (
  input wire        gclk,
  input wire        grst,
  input wire [31:0] imemAddr_o,
  input wire        imemEn_o,
  input wire        imemBusyN_i,
  input wire [31:0] dmemAddr_o,
  input wire        dmemWe_o,
  input wire        dmemEn_o,
  input wire        dmemBusyN_i
);

  int failCount = 0;    // Read by the testbench at the end

  // Enables low once reset has been seen for a full cycle
  assert property (@(posedge gclk) (!grst && $past(!grst)) |-> (!imemEn_o && !dmemEn_o && !dmemWe_o))
    else
    begin
      $error("enable high during reset");
      failCount++;
    end

  // Frozen cycle keeps every request as it was
  assert property (@(posedge gclk) (grst && !(imemBusyN_i && dmemBusyN_i)) |=>
                   ($stable(imemEn_o) && $stable(dmemEn_o) && $stable(dmemWe_o)
                    && (!imemEn_o || $stable(imemAddr_o))
                    && (!dmemEn_o || $stable(dmemAddr_o))))
    else
    begin
      $error("request changed while busy");
      failCount++;
    end

  assert property (@(posedge gclk) dmemWe_o |-> dmemEn_o)
    else
    begin
      $error("write strobe without enable");
      failCount++;
    end

  assert property (@(posedge gclk) (dmemEn_o && dmemWe_o) |-> (dmemAddr_o[1:0] == 2'b00))
    else
    begin
      $error("unaligned store address");
      failCount++;
    end

endmodule

bind mbCore mbCore_checker checker_i (.*);

`default_nettype wire

// ==== tb/mbCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none
`include "mbCore_config.svh"

module mbCoreTb;

  logic        gclk;
  logic        grst;
  logic [31:0] imemAddr;
  logic        imemEn;
  logic [31:0] imemData;
  logic        imemBusyN;
  logic [31:0] dmemAddr;
  logic [31:0] dmemWdata;
  logic        dmemWe;
  logic        dmemEn;
  logic [31:0] dmemData;
  logic        dmemBusyN;

  logic [31:0] prog [64];
  logic [31:0] dmem [256];
  logic [31:0] expAddr [$];
  logic [31:0] expData [$];
  logic [31:0] lfsr;
  logic        randomBusy;
  logic        advS;             // Advance seen in the cycle just sampled
  logic        iFetch;
  logic        dLoad;
  logic [31:0] iNext;
  logic [31:0] dNext;
  logic        firstSeen;
  logic [31:0] firstAddr;
  int          storeIdx;
  int          errors;
  int          testsRun;
  int          testsFailed;
  int          pc;

  localparam logic [31:0] VA = 32'd100;         // r1
  localparam logic [31:0] VB = 32'hFFFF_FFF9;   // r2, -7

  mbCore mbCore_i (
    .gclk        (gclk),
    .grst        (grst),
    .imemAddr_o  (imemAddr),
    .imemEn_o    (imemEn),
    .imemData_i  (imemData),
    .imemBusyN_i (imemBusyN),
    .dmemAddr_o  (dmemAddr),
    .dmemData_o  (dmemWdata),
    .dmemWe_o    (dmemWe),
    .dmemEn_o    (dmemEn),
    .dmemData_i  (dmemData),
    .dmemBusyN_i (dmemBusyN)
  );

  always #10 gclk = ~gclk;

  function automatic logic [31:0] lfsrStep(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hD000_0001) : (s >> 1);
  endfunction

  function automatic logic [31:0] fillWord(input logic [7:0] idx);
    return {idx, ~idx, idx ^ 8'h5A, idx + 8'hC3};   // Every byte tied to the index
  endfunction

  function automatic logic [31:0] encA(input logic [5:0] op, input logic [4:0] rd,
                                      input logic [4:0] ra, input logic [4:0] rb);
    return {op, rd, ra, rb, 11'd0};
  endfunction

  function automatic logic [31:0] encB(input logic [5:0] op, input logic [4:0] rd,
                                      input logic [4:0] ra, input logic [15:0] imm);
    return {op | (6'd1 << `MB_OP_IMM_BIT), rd, ra, imm};
  endfunction

  task automatic emit(input logic [31:0] w);
    prog[pc] = w;
    pc++;
  endtask

  task automatic expectStore(input logic [31:0] a, input logic [31:0] d);
    expAddr.push_back(a);
    expData.push_back(d);
  endtask

  task automatic buildProgram;
    for (int i = 0; i < 64; i++)
      prog[i] = encB(`MB_OP_BRI, 5'd0, 5'd0, 16'd0);   // Park on self loop
    pc = 0;
    emit(encB(`MB_OP_ADDK, 5'd1, 5'd0, 16'd100));
    emit(encB(`MB_OP_ADDK, 5'd2, 5'd0, 16'hFFF9));       // Negative imm
    emit(encA(`MB_OP_ADDK, 5'd3, 5'd1, 5'd2));           // Back to back use
    emit(encA(`MB_OP_RSUBK, 5'd4, 5'd1, 5'd2));
    emit(encA(`MB_OP_AND, 5'd5, 5'd1, 5'd2));
    emit(encA(`MB_OP_OR, 5'd6, 5'd1, 5'd2));
    emit(encA(`MB_OP_XOR, 5'd7, 5'd1, 5'd2));
    for (int r = 3; r <= 7; r++)
      emit(encB(`MB_OP_SWI, 5'(r), 5'd0, 16'(16'h200 + (r - 3) * 4)));
    emit(encB(`MB_OP_RSUBK, 5'd8, 5'd1, 16'hFFF9));
    emit(encB(`MB_OP_ADDK, 5'd9, 5'd1, 16'hFFF9));
    emit(encB(`MB_OP_AND, 5'd10, 5'd1, 16'hFFF9));
    emit(encB(`MB_OP_OR, 5'd11, 5'd1, 16'hFFF9));
    emit(encB(`MB_OP_XOR, 5'd12, 5'd1, 16'hFFF9));
    for (int r = 8; r <= 12; r++)
      emit(encB(`MB_OP_SWI, 5'(r), 5'd0, 16'(16'h214 + (r - 8) * 4)));
    emit(encB(`MB_OP_LWI, 5'd13, 5'd0, 16'h40));
    emit(encA(`MB_OP_ADDK, 5'd14, 5'd13, 5'd1));         // Load-use on ra
    emit(encB(`MB_OP_SWI, 5'd14, 5'd0, 16'h228));
    emit(encB(`MB_OP_LWI, 5'd15, 5'd0, 16'h44));
    emit(encB(`MB_OP_SWI, 5'd15, 5'd0, 16'h22C));        // Load-use on store data
    emit(encB(`MB_OP_ADDK, 5'd0, 5'd1, 16'd5));          // r0 must stay zero
    emit(encB(`MB_OP_SWI, 5'd0, 5'd0, 16'h230));
    emit(encA(`MB_OP_ADDK, 5'd16, 5'd0, 5'd1));
    emit(encB(`MB_OP_SWI, 5'd16, 5'd0, 16'h234));
    emit(encB(`MB_OP_BRI, 5'd0, 5'd0, 16'd12));          // Skips two stores
    emit(encB(`MB_OP_SWI, 5'd1, 5'd0, 16'h300));
    emit(encB(`MB_OP_SWI, 5'd1, 5'd0, 16'h304));
    emit(encB(`MB_OP_BEQI, 5'd0, 5'd0, 16'd12));         // r0 zero, taken
    emit(encB(`MB_OP_SWI, 5'd1, 5'd0, 16'h308));
    emit(encB(`MB_OP_SWI, 5'd1, 5'd0, 16'h30C));
    emit(encB(`MB_OP_BEQI, 5'd0, 5'd1, 16'd12));         // r1 nonzero, falls through
    emit(encB(`MB_OP_SWI, 5'd1, 5'd0, 16'h238));
    emit(encB(`MB_OP_SWI, 5'd2, 5'd0, 16'h23C));
    // Expected stores from the ISA rules, rsub is B minus A
    expectStore(32'h200, VA + VB);
    expectStore(32'h204, VB - VA);
    expectStore(32'h208, VA & VB);
    expectStore(32'h20C, VA | VB);
    expectStore(32'h210, VA ^ VB);
    expectStore(32'h214, VB - VA);
    expectStore(32'h218, VA + VB);
    expectStore(32'h21C, VA & VB);
    expectStore(32'h220, VA | VB);
    expectStore(32'h224, VA ^ VB);
    expectStore(32'h228, fillWord(8'h10) + VA);
    expectStore(32'h22C, fillWord(8'h11));
    expectStore(32'h230, 32'd0);
    expectStore(32'h234, VA);
    expectStore(32'h238, VA);
    expectStore(32'h23C, VB);
  endtask

  task automatic checkStore(input logic [31:0] a, input logic [31:0] d);
    assert (storeIdx < expAddr.size())
    else
    begin
      $display("Unexpected extra store at time %0t to address %h", $time, a);
      errors++;
    end
    if (storeIdx < expAddr.size())
    begin
      assert (a == expAddr[storeIdx])
      else
      begin
        $display("MISMATCH time %0t dmemAddr_o got %h expected %h", $time, a, expAddr[storeIdx]);
        errors++;
      end
      assert (d == expData[storeIdx])
      else
      begin
        $display("MISMATCH time %0t dmemData_o got %h expected %h", $time, d, expData[storeIdx]);
        errors++;
      end
    end
    storeIdx++;
  endtask

  // Memory models sample mid cycle, answer just after the edge
  always @(negedge gclk)
  begin
    advS   = imemBusyN & dmemBusyN;
    iFetch = imemEn;
    iNext  = prog[imemAddr[7:2]];
    dLoad  = dmemEn & ~dmemWe;
    dNext  = dmem[dmemAddr[9:2]];
    if (grst && imemEn && !firstSeen)
    begin
      firstSeen = 1'b1;
      firstAddr = imemAddr;
    end
    if (grst && advS && dmemEn && dmemWe)
    begin
      checkStore(dmemAddr, dmemWdata);
      dmem[dmemAddr[9:2]] = dmemWdata;
    end
  end

  always @(posedge gclk)
  begin
    #1;
    if (advS && iFetch)
      imemData = iNext;
    if (advS && dLoad)
      dmemData = dNext;
    if (randomBusy)
    begin
      lfsr      = lfsrStep(lfsr);
      imemBusyN = lfsr[0];
      lfsr      = lfsrStep(lfsr);
      dmemBusyN = lfsr[0];
    end
    else
    begin
      imemBusyN = 1'b1;
      dmemBusyN = 1'b1;
    end
  end

  task automatic runPass(input logic rnd, input string name);
    int startErr;
    int cnt;
    startErr = errors;
    storeIdx = 0;
    for (int i = 0; i < 256; i++)
      dmem[i] = fillWord(8'(i));
    @(posedge gclk);
    #1 grst = 1'b0;
    firstSeen = 1'b0;             // Fetches from the last run are ignored
    repeat (5) @(posedge gclk);
    randomBusy = rnd;             // Busy driver picks it up at the 1 ns step
    #1 grst = 1'b1;
    cnt = 0;
    while (storeIdx < expAddr.size() && cnt < 4000)
    begin
      @(posedge gclk);
      cnt++;
    end
    assert (storeIdx >= expAddr.size())
    else
    begin
      $display("Timed out in %s with %0d of %0d stores", name, storeIdx, expAddr.size());
      errors++;
    end
    cnt = 0;
    while (cnt < 60)              // Window for stray stores after the last one
    begin
      @(posedge gclk);
      cnt++;
    end
    randomBusy = 1'b0;
    assert (firstSeen)
    else
    begin
      $display("No instruction fetch seen after reset in %s", name);
      errors++;
    end
    if (firstSeen)
    begin
      assert (firstAddr == `MB_RESET_PC)
      else
      begin
        $display("MISMATCH time %0t imemAddr_o got %h expected %h",
                 $time, firstAddr, `MB_RESET_PC);
        errors++;
      end
    end
    testsRun++;
    if (errors != startErr)
      testsFailed++;
    $display("test %s: %s", name, (errors == startErr) ? "ok" : "failed");
  endtask

  initial
  begin
    gclk       = 1'b0;
    grst       = 1'b0;
    imemData   = 32'd0;
    dmemData   = 32'd0;
    imemBusyN  = 1'b1;
    dmemBusyN  = 1'b1;
    randomBusy = 1'b0;
    advS       = 1'b0;
    iFetch     = 1'b0;
    dLoad      = 1'b0;
    lfsr       = 32'h37eace9d;
    errors     = 0;
    testsRun   = 0;
    testsFailed = 0;
    buildProgram();
    runPass(1'b0, "program no busy");
    runPass(1'b1, "program random busy");
    errors += mbCore_i.checker_i.failCount;
    $display("tests %0d, failed %0d, errors %0d", testsRun, testsFailed, errors);
    if (errors == 0)
      $display("SIMULATION PASSED");
    else
      $display("SIMULATION FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+design
design/mbCore_pkg.sv
design/mbFetch.sv
design/mbDecode.sv
design/mbRegFile.sv
design/mbExecute.sv
design/mbCore.sv
tb/mbCore_checker.sv
tb/mbCoreTb.sv

// ==== run.sh ====
#!/bin/bash
# Build with Verilator, run, then judge the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module mbCoreTb -o mbCoreSim \
  && ./obj_dir/mbCoreSim > sim.log 2>&1 \
  || { cat sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
! grep -q "SIMULATION FAILED" sim.log && grep -q "SIMULATION PASSED" sim.log \
  || exit 1
